/* project.f */
walksat_pkg.sv
break_value_counter.sv
heuristic_selector.sv
flip_selector.sv
flip_sequencer.sv
apb_flip_regs.sv
walksat_flip_top.sv
walksat_flip_asserts.sv
tb_walksat_flip.sv

/* run.sh */
#!/bin/sh
# build and run the flip stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_walksat_flip -f project.f -o sim_walksat_flip > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_walksat_flip > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

/* tb_walksat_flip.sv */
/*
 Directed testbench for the WalkSAT flip stage.
 Streams candidate groups into the top level, predicts each pick from the
 freebie, random-walk and greedy rules, and checks results and APB reads.
*/

`timescale 1ns/100ps

module tb_walksat_flip;

    import walksat_pkg::*;

    localparam logic [31:0] P_RESET = 32'h6E14_7AE0;
    localparam int          TIMEOUT = 50;

    logic         clk;
    logic         reset;
    cand_row_t    row;
    logic         row_valid;
    logic         row_ready;
    logic [31:0]  random;
    flip_result_t result;
    logic         result_valid;
    logic         result_ready;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;

    // lfsr state, current group and register shadows
    logic [31:0]     lfsr;
    cand_row_t       grp [NSAT];
    logic [31:0]     thr_model;
    logic [NSAT-1:0] mask_model;
    int              picks;
    int              tests;
    int              checks;
    int              errors;

    walksat_flip_top #(
        .P_RESET (P_RESET)
    ) i_dut (
        .clk            (clk),
        .reset          (reset),
        .row_i          (row),
        .row_valid_i    (row_valid),
        .row_ready_o    (row_ready),
        .random_i       (random),
        .result_o       (result),
        .result_valid_o (result_valid),
        .result_ready_i (result_ready),
        .apb_i          (apb_req),
        .apb_o          (apb_rsp)
    );

    always #50 clk = ~clk;

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = galois_step(lfsr);
        end
    endtask

    task automatic random_row(input logic force_break, output cand_row_t r);
        logic [31:0] b;
        logic [31:0] m;
        take_bits(MAX_CLAUSES, b);
        take_bits(MAX_CLAUSES, m);
        r.clause_broken = b[MAX_CLAUSES-1:0];
        r.mask          = m[MAX_CLAUSES-1:0];
        // at least one masked broken clause
        if (force_break) begin
            r.clause_broken[0] = 1'b1;
            r.mask[0]          = 1'b1;
        end
    endtask

    // reference pick straight from the heuristic rules
    function automatic flip_result_t predict(input logic [NSAT-1:0] vmask,
                                             input logic [31:0] rnd, input logic [31:0] thr);
        int           bv [NSAT];
        int           pick;
        int           walk_idx;
        flip_result_t res;
        pick = NSAT;
        for (int k = 0; k < NSAT; k++) begin
            bv[k] = $countones(grp[k].clause_broken & grp[k].mask);
        end
        for (int k = 0; k < NSAT; k++) begin
            if (pick == NSAT && vmask[k] && bv[k] == 0) begin
                pick = k;
            end
        end
        if (pick == NSAT && vmask != '0) begin
            walk_idx = int'(rnd % 32'(NSAT));
            if (rnd < thr && vmask[walk_idx]) begin
                pick = walk_idx;
            end else begin
                for (int k = 0; k < NSAT; k++) begin
                    // walk fallback takes the first valid and greedy the smallest
                    if (vmask[k] && (pick == NSAT || (rnd >= thr && bv[k] < bv[pick]))) begin
                        pick = k;
                    end
                end
            end
        end
        res.selected = NSAT_BITS'(pick);
        if (pick == NSAT) begin
            res.broken_bits = '0;
        end else begin
            res.broken_bits = grp[pick].clause_broken & grp[pick].mask;
        end
        return res;
    endfunction

    task automatic check_result(input flip_result_t got, input flip_result_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got index %0d bits %h, expected index %0d bits %h",
                     $time, what, got.selected, got.broken_bits, exp.selected,
                     exp.broken_bits);
        end
    endtask

    task automatic check_apb(input apb_rsp_t got, input apb_rsp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got data %h err %b, expected data %h err %b",
                     $time, what, got.prdata, got.pslverr, exp.prdata, exp.pslverr);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timed out waiting for %s at %0t ns", what, $time);
        $display("Test failed");
        $finish;
    endtask

    // apb setup then access with read data taken late in the access cycle
    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              output apb_rsp_t rsp);
        int n;
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
        n = 0;
        #25;
        while (!apb_rsp.pready && n < TIMEOUT) begin
            @(negedge clk);
            #25;
            n++;
        end
        if (!apb_rsp.pready) begin
            abort_run("apb pready");
        end
        rsp = apb_rsp;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic set_threshold(input logic [31:0] value);
        apb_rsp_t rsp;
        apb_access(1'b1, REG_THRESHOLD, value, rsp);
        thr_model = value;
    endtask

    task automatic set_mask(input logic [NSAT-1:0] value);
        apb_rsp_t rsp;
        apb_access(1'b1, REG_VALID_MASK, 32'(value), rsp);
        mask_model = value;
    endtask

    task automatic send_row(input cand_row_t r);
        int n;
        @(negedge clk);
        row       = r;
        row_valid = 1'b1;
        n = 0;
        while (!row_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!row_ready) begin
            abort_run("row_ready");
        end
        // transfer happens on the next rising edge
        @(negedge clk);
        row_valid = 1'b0;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        while (!result_valid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!result_valid) begin
            abort_run("result_valid");
        end
    endtask

    task automatic take_result();
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        picks++;
    endtask

    // full group through the dut, checked against the model
    task automatic run_group(input logic [31:0] rnd, input string what);
        flip_result_t exp;
        exp = predict(mask_model, rnd, thr_model);
        @(negedge clk);
        random = rnd;
        for (int k = 0; k < NSAT; k++) begin
            send_row(grp[k]);
        end
        wait_result();
        check_result(result, exp, what);
        take_result();
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        $display("%-14s done, %0d errors", name, errors - errs_before);
    endtask

    task automatic test_registers();
        int       e;
        apb_rsp_t rsp;
        e = errors;
        apb_access(1'b0, REG_THRESHOLD, '0, rsp);
        check_apb(rsp, '{prdata: P_RESET, pready: 1'b1, pslverr: 1'b0}, "threshold reset");
        apb_access(1'b0, REG_VALID_MASK, '0, rsp);
        check_apb(rsp, '{prdata: 32'h7, pready: 1'b1, pslverr: 1'b0}, "mask reset");
        apb_access(1'b0, REG_PICK_COUNT, '0, rsp);
        check_apb(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b0}, "count reset");
        set_threshold(32'h1234_5678);
        apb_access(1'b0, REG_THRESHOLD, '0, rsp);
        check_apb(rsp, '{prdata: 32'h1234_5678, pready: 1'b1, pslverr: 1'b0}, "threshold rw");
        apb_access(1'b0, 4'hC, '0, rsp);
        check_apb(rsp, '{prdata: 32'h0, pready: 1'b1, pslverr: 1'b1}, "unmapped read");
        report_test("registers", e);
    endtask

    task automatic test_freebie();
        int          e;
        logic [31:0] rnd;
        e = errors;
        // every non-empty set of zero-break rows
        for (int z = 1; z < (1 << NSAT); z++) begin
            for (int k = 0; k < NSAT; k++) begin
                random_row(1'b1, grp[k]);
                if (z[k]) begin
                    grp[k].clause_broken = grp[k].clause_broken & ~grp[k].mask;
                end
            end
            take_bits(32, rnd);
            run_group(rnd, "freebie");
        end
        report_test("freebie", e);
    endtask

    task automatic test_greedy();
        int          e;
        logic [31:0] rnd;
        e = errors;
        set_threshold(32'h0);
        for (int g = 0; g < 8; g++) begin
            for (int k = 0; k < NSAT; k++) begin
                random_row(1'b0, grp[k]);
            end
            take_bits(32, rnd);
            run_group(rnd, "greedy");
        end
        // equal break values on every row
        random_row(1'b1, grp[0]);
        grp[1] = grp[0];
        grp[2] = grp[0];
        run_group(32'h5, "greedy tie");
        report_test("greedy", e);
    endtask

    task automatic test_random_walk();
        int          e;
        logic [31:0] rnd;
        e = errors;
        set_threshold('1);
        for (int g = 0; g < 6; g++) begin
            for (int k = 0; k < NSAT; k++) begin
                random_row(1'b1, grp[k]);
            end
            take_bits(32, rnd);
            run_group(rnd, "random walk");
        end
        // lowest valid takes over when the target is masked out
        // break values 20, 10 and 1 so a greedy pick would differ
        grp[0].clause_broken = '1;
        grp[0].mask          = '1;
        grp[1].clause_broken = '1;
        grp[1].mask          = 20'h003FF;
        grp[2].clause_broken = '1;
        grp[2].mask          = 20'h00001;
        take_bits(31, rnd);
        rnd = rnd - (rnd % 32'(NSAT)) + 32'd2;
        set_mask(3'b011);
        run_group(rnd, "walk fallback to 0");
        rnd = rnd - 32'd2;
        set_mask(3'b110);
        run_group(rnd, "walk fallback to 1");
        set_mask(3'b111);
        report_test("random walk", e);
    endtask

    task automatic test_backpressure();
        int           e;
        logic [31:0]  rnd;
        flip_result_t exp;
        cand_row_t    junk;
        apb_rsp_t     rsp;
        e = errors;
        for (int k = 0; k < NSAT; k++) begin
            random_row(1'b0, grp[k]);
        end
        take_bits(32, rnd);
        exp = predict(mask_model, rnd, thr_model);
        @(negedge clk);
        random = rnd;
        for (int k = 0; k < NSAT; k++) begin
            send_row(grp[k]);
        end
        wait_result();
        // offer rows while the result sits unclaimed
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            random_row(1'b0, junk);
            row       = junk;
            row_valid = 1'b1;
            check_flag(row_ready, 1'b0, "row_ready while pending");
            check_flag(result_valid, 1'b1, "result_valid while pending");
            check_result(result, exp, "held result");
        end
        row_valid = 1'b0;
        take_result();
        for (int k = 0; k < NSAT; k++) begin
            random_row(1'b0, grp[k]);
        end
        take_bits(32, rnd);
        run_group(rnd, "after release");
        apb_access(1'b0, REG_PICK_COUNT, '0, rsp);
        check_apb(rsp, '{prdata: 32'(picks), pready: 1'b1, pslverr: 1'b0}, "pick count");
        report_test("backpressure", e);
    endtask

    task automatic test_no_valid();
        int          e;
        logic [31:0] rnd;
        e = errors;
        set_mask('0);
        for (int k = 0; k < NSAT; k++) begin
            random_row(1'b0, grp[k]);
        end
        take_bits(32, rnd);
        run_group(rnd, "no valid");
        set_mask('1);
        report_test("no valid", e);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        row          = '0;
        row_valid    = 1'b0;
        random       = '0;
        result_ready = 1'b0;
        apb_req      = '0;
        lfsr         = 32'd98;
        thr_model    = P_RESET;
        mask_model   = '1;
        picks        = 0;
        tests        = 0;
        checks       = 0;
        errors       = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_registers();
        test_freebie();
        test_greedy();
        test_random_walk();
        test_backpressure();
        test_no_valid();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* walksat_flip_asserts.sv */
/*
 Concurrent checks on the flip sequencer handshake and write code.
 Bound into every flip_sequencer instance at the bottom of this file.
*/

`timescale 1ns/100ps

module walksat_flip_asserts (
    input logic               clk,
    input logic               reset,
    input logic               row_valid_i,
    input logic               row_ready_i,
    input logic               result_valid_i,
    input logic               result_ready_i,
    input walksat_pkg::wren_t wren_i
);

    // write code leaves idle exactly when a row moves
    a_wren_on_fire: assert property (@(posedge clk) disable iff (reset)
        (wren_i != '0) == (row_valid_i && row_ready_i))
        else $error("write code %b does not match the row transfer", wren_i);

    // pending result stays until handed over
    a_valid_hold: assert property (@(posedge clk) disable iff (reset)
        result_valid_i && !result_ready_i |=> result_valid_i)
        else $error("result valid dropped before the result was taken");

    // no row moves and no write code while a result is pending
    a_no_row_pending: assert property (@(posedge clk) disable iff (reset)
        result_valid_i |-> !(row_valid_i && row_ready_i) && (wren_i == '0))
        else $error("row accepted while a result was pending");

endmodule

bind flip_sequencer walksat_flip_asserts i_asserts (
    .clk            (clk),
    .reset          (reset),
    .row_valid_i    (row_valid_i),
    .row_ready_i    (row_ready_o),
    .result_valid_i (result_valid_o),
    .result_ready_i (result_ready_i),
    .wren_i         (wren_o)
);

/* walksat_flip_top.sv */
/*
 Top of the WalkSAT variable flip stage.
 Row stream in, chosen variable out, APB for threshold and valid mask.
*/

`timescale 1ns/100ps

module walksat_flip_top #(
    parameter logic [31:0] P_RESET = 32'h6E14_7AE0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  walksat_pkg::cand_row_t    row_i,
    input  logic                      row_valid_i,
    output logic                      row_ready_o,
    input  logic [31:0]               random_i,
    output walksat_pkg::flip_result_t result_o,
    output logic                      result_valid_o,
    input  logic                      result_ready_i,
    input  walksat_pkg::apb_req_t     apb_i,
    output walksat_pkg::apb_rsp_t     apb_o
);

    import walksat_pkg::*;

    wren_t            wren;
    logic             pick;
    logic [31:0]      threshold;
    logic [NSAT-1:0]  valid_mask;

    // handshake and write code
    flip_sequencer i_sequencer (
        .clk            (clk),
        .reset          (reset),
        .row_valid_i    (row_valid_i),
        .row_ready_o    (row_ready_o),
        .result_valid_o (result_valid_o),
        .result_ready_i (result_ready_i),
        .wren_o         (wren),
        .pick_o         (pick)
    );

    // break values and the pick
    flip_selector i_selector (
        .clk          (clk),
        .reset        (reset),
        .row_i        (row_i),
        .wren_i       (wren),
        .valid_mask_i (valid_mask),
        .threshold_i  (threshold),
        .random_i     (random_i),
        .result_o     (result_o)
    );

    apb_flip_regs #(
        .P_RESET (P_RESET)
    ) i_regs (
        .clk          (clk),
        .reset        (reset),
        .apb_i        (apb_i),
        .apb_o        (apb_o),
        .pick_i       (pick),
        .threshold_o  (threshold),
        .valid_mask_o (valid_mask)
    );

endmodule

/* apb_flip_regs.sv */
/*
 APB3 register block of the flip stage.
 Threshold and candidate valid mask are read/write, the pick counter is
 read only. No wait states, unmapped offsets return pslverr.
*/

`timescale 1ns/100ps

module apb_flip_regs #(
    parameter logic [31:0] P_RESET = 32'h6E14_7AE0
) (
    input  logic                         clk,
    input  logic                         reset,
    input  walksat_pkg::apb_req_t        apb_i,
    output walksat_pkg::apb_rsp_t        apb_o,
    input  logic                         pick_i,
    output logic [31:0]                  threshold_o,
    output logic [walksat_pkg::NSAT-1:0] valid_mask_o
);

    import walksat_pkg::*;

    logic        access;
    logic        wr_en;
    logic        addr_hit;
    logic [31:0] rdata;
    logic [31:0] pick_count;

    // access phase of a selected transfer
    assign access = apb_i.psel & apb_i.penable;
    assign wr_en  = access & apb_i.pwrite;

    // writes land at the access-phase edge
    // counter offset ignores writes
    always_ff @(posedge clk) begin
        if (reset) begin
            threshold_o  <= P_RESET;
            valid_mask_o <= '1;
        end else if (wr_en) begin
            if (apb_i.paddr == REG_THRESHOLD) begin
                threshold_o <= apb_i.pwdata;
            end
            if (apb_i.paddr == REG_VALID_MASK) begin
                valid_mask_o <= apb_i.pwdata[NSAT-1:0];
            end
        end
    end

    // one count per result handed over
    always_ff @(posedge clk) begin
        if (reset) begin
            pick_count <= '0;
        end else if (pick_i) begin
            pick_count <= pick_count + 32'd1;
        end
    end

    // read mux
    always_comb begin
        rdata    = '0;
        addr_hit = 1'b1;
        case (apb_i.paddr)
            REG_THRESHOLD:  rdata = threshold_o;
            REG_VALID_MASK: rdata = 32'(valid_mask_o);
            REG_PICK_COUNT: rdata = pick_count;
            default:        addr_hit = 1'b0;
        endcase
    end

    assign apb_o = '{prdata: rdata, pready: 1'b1, pslverr: access & ~addr_hit};

endmodule

/* flip_sequencer.sv */
/*
 Row stream sequencer for the flip stage.
 Counts row transfers, issues the write code for each row, raises result
 valid after the last row and blocks new rows until the result is taken.
*/

`timescale 1ns/100ps

module flip_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               row_valid_i,
    output logic               row_ready_o,
    output logic               result_valid_o,
    input  logic               result_ready_i,
    output walksat_pkg::wren_t wren_o,
    output logic               pick_o
);

    import walksat_pkg::*;

    // index of the next row within the group
    logic [NSAT_BITS-1:0] row_cnt;
    logic                 row_fire;
    logic                 last_row;

    // back-pressure while a result is pending
    assign row_ready_o = ~result_valid_o;
    assign row_fire    = row_valid_i & row_ready_o;
    assign last_row    = row_cnt == NSAT_BITS'(NSAT - 1);

    // result handed over this cycle
    assign pick_o = result_valid_o & result_ready_i;

    // idle unless a row moves
    // one-hot for held rows, all ones on the last
    always_comb begin
        wren_o = '0;
        if (row_fire) begin
            if (last_row) begin
                wren_o = '1;
            end else begin
                wren_o = wren_t'(1) << row_cnt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            row_cnt <= '0;
        end else if (row_fire) begin
            if (last_row) begin
                row_cnt <= '0;
            end else begin
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // set after the group closes, cleared on handover
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid_o <= 1'b0;
        end else if (row_fire && last_row) begin
            result_valid_o <= 1'b1;
        end else if (pick_o) begin
            result_valid_o <= 1'b0;
        end
    end

endmodule

/* flip_selector.sv */
/*
 Variable flip selector datapath.
 Holds break values and masked bits of the first NSAT-1 rows, then on the
 select code runs the heuristic over stored slots plus the live last row
 and registers the chosen index with that row's bits.
*/

`timescale 1ns/100ps

module flip_selector (
    input  logic                          clk,
    input  logic                          reset,
    input  walksat_pkg::cand_row_t        row_i,
    input  walksat_pkg::wren_t            wren_i,
    input  logic [walksat_pkg::NSAT-1:0]  valid_mask_i,
    input  logic [31:0]                   threshold_i,
    input  logic [31:0]                   random_i,
    output walksat_pkg::flip_result_t     result_o
);

    import walksat_pkg::*;

    // number of held rows
    localparam int NSLOT = NSAT - 1;

    break_t                 live_bv;
    logic [MAX_CLAUSES-1:0] live_bits;
    break_t                 slot_bv   [NSLOT];
    logic [MAX_CLAUSES-1:0] slot_bits [NSLOT];

    logic [NSAT*MAX_CLAUSES_BITS-1:0] all_bv;
    logic [NSAT_BITS-1:0]             select;
    logic [MAX_CLAUSES-1:0]           select_bits;
    logic                             do_select;

    assign do_select = &wren_i;

    break_value_counter i_counter (
        .row_i         (row_i),
        .break_value_o (live_bv),
        .broken_bits_o (live_bits)
    );

    // stored slots low, live row in the top position
    always_comb begin
        for (int k = 0; k < NSLOT; k++) begin
            all_bv[k*MAX_CLAUSES_BITS +: MAX_CLAUSES_BITS] = slot_bv[k];
        end
        all_bv[NSLOT*MAX_CLAUSES_BITS +: MAX_CLAUSES_BITS] = live_bv;
    end

    heuristic_selector i_heuristic (
        .break_values_i (all_bv),
        .valid_i        (valid_mask_i),
        .random_i       (random_i),
        .threshold_i    (threshold_i),
        .select_o       (select)
    );

    // one-hot k stores row k
    always_ff @(posedge clk) begin
        for (int k = 0; k < NSLOT; k++) begin
            if (wren_i == wren_t'(1 << k)) begin
                slot_bv[k]   <= live_bv;
                slot_bits[k] <= live_bits;
            end
        end
    end

    // bits of the chosen row, zero for the none code
    always_comb begin
        select_bits = '0;
        if (select == NSAT_BITS'(NSLOT)) begin
            select_bits = live_bits;
        end
        for (int k = 0; k < NSLOT; k++) begin
            if (select == NSAT_BITS'(k)) begin
                select_bits = slot_bits[k];
            end
        end
    end

    // result updates on the last row's transfer edge
    always_ff @(posedge clk) begin
        if (reset) begin
            result_o.selected    <= NSAT_BITS'(NSAT);
            result_o.broken_bits <= '0;
        end else if (do_select) begin
            result_o.selected    <= select;
            result_o.broken_bits <= select_bits;
        end
    end

endmodule

/* heuristic_selector.sv */
/*
 WalkSAT pick over NSAT candidate break values.
 Freebie move first, then random walk when random is below threshold,
 otherwise greedy minimum. Lowest index wins every tie, NSAT means none.
*/

`timescale 1ns/100ps

module heuristic_selector (
    input  logic [walksat_pkg::NSAT*walksat_pkg::MAX_CLAUSES_BITS-1:0] break_values_i,
    input  logic [walksat_pkg::NSAT-1:0]      valid_i,
    input  logic [31:0]                       random_i,
    input  logic [31:0]                       threshold_i,
    output logic [walksat_pkg::NSAT_BITS-1:0] select_o
);

    import walksat_pkg::*;

    // unpacked view of the break values
    break_t bv [NSAT];

    logic                 any_valid;
    logic                 free_hit;
    logic [NSAT_BITS-1:0] free_idx;
    logic [NSAT_BITS-1:0] low_idx;
    logic [NSAT_BITS-1:0] greedy_idx;
    break_t               greedy_bv;
    logic                 greedy_found;
    logic                 walk;
    logic [NSAT_BITS-1:0] rand_idx;

    always_comb begin
        for (int k = 0; k < NSAT; k++) begin
            bv[k] = break_values_i[k*MAX_CLAUSES_BITS +: MAX_CLAUSES_BITS];
        end
    end

    // scan downwards so the lowest index is the last one written
    always_comb begin
        any_valid = 1'b0;
        free_hit  = 1'b0;
        free_idx  = '0;
        low_idx   = '0;
        for (int k = NSAT - 1; k >= 0; k--) begin
            if (valid_i[k]) begin
                any_valid = 1'b1;
                low_idx   = NSAT_BITS'(k);
                if (bv[k] == '0) begin
                    free_hit = 1'b1;
                    free_idx = NSAT_BITS'(k);
                end
            end
        end
    end

    // greedy minimum, strict compare keeps the earlier index on ties
    always_comb begin
        greedy_found = 1'b0;
        greedy_idx   = '0;
        greedy_bv    = '0;
        for (int k = 0; k < NSAT; k++) begin
            if (valid_i[k] && (!greedy_found || bv[k] < greedy_bv)) begin
                greedy_found = 1'b1;
                greedy_idx   = NSAT_BITS'(k);
                greedy_bv    = bv[k];
            end
        end
    end

    // random walk target
    assign walk     = random_i < threshold_i;
    assign rand_idx = NSAT_BITS'(random_i % 32'(NSAT));

    always_comb begin
        if (!any_valid) begin
            select_o = NSAT_BITS'(NSAT);
        end else if (free_hit) begin
            select_o = free_idx;
        end else if (walk) begin
            // masked target falls back to lowest valid
            select_o = valid_i[rand_idx] ? rand_idx : low_idx;
        end else begin
            select_o = greedy_idx;
        end
    end

endmodule

/* break_value_counter.sv */
/*
 Break value of one candidate row.
 Masks the clause-broken bits with the occurrence mask and counts the
 ones that remain. Purely combinational.
*/

`timescale 1ns/100ps

module break_value_counter (
    input  walksat_pkg::cand_row_t         row_i,
    output walksat_pkg::break_t            break_value_o,
    output logic [walksat_pkg::MAX_CLAUSES-1:0] broken_bits_o
);

    import walksat_pkg::*;

    // running count over the clause slots
    break_t count;

    // only clauses this variable actually occurs in
    assign broken_bits_o = row_i.clause_broken & row_i.mask;

    // popcount of the masked bits
    // 20 slots fit in 5 bits so no overflow
    always_comb begin
        count = '0;
        for (int c = 0; c < MAX_CLAUSES; c++) begin
            count = count + break_t'(broken_bits_o[c]);
        end
    end

    assign break_value_o = count;

endmodule

/* walksat_pkg.sv */
/*
 Shared sizes, types and register offsets for the WalkSAT flip stage.
 Imported by every design module and by the testbench.
*/

package walksat_pkg;

    // clause slots per variable and width of a break value
    localparam int MAX_CLAUSES      = 20;
    localparam int MAX_CLAUSES_BITS = $clog2(MAX_CLAUSES + 1);

    // literals per clause, index NSAT is the none code
    localparam int NSAT      = 3;
    localparam int NSAT_BITS = $clog2(NSAT + 1);

    // break value of one candidate
    typedef logic [MAX_CLAUSES_BITS-1:0] break_t;

    // write code from sequencer to selector
    // zero is idle, one-hot k holds row k, all ones runs the select
    typedef logic [NSAT_BITS-1:0] wren_t;

    // one candidate row as streamed in by the controller
    typedef struct packed {
        logic [MAX_CLAUSES-1:0] clause_broken;
        logic [MAX_CLAUSES-1:0] mask;
    } cand_row_t;

    // chosen variable and its masked broken bits
    typedef struct packed {
        logic [NSAT_BITS-1:0]   selected;
        logic [MAX_CLAUSES-1:0] broken_bits;
    } flip_result_t;

    // apb3 request and response
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register byte offsets
    localparam logic [3:0] REG_THRESHOLD  = 4'h0;
    localparam logic [3:0] REG_VALID_MASK = 4'h4;
    localparam logic [3:0] REG_PICK_COUNT = 4'h8;

endpackage
